// File: design/uart_pkg.sv
// Fixed frame of 1 start, 8 data and 1 stop bit, no parity
// Bit length is a whole number of system clocks, no fractional baud
// Both FIFOs share one depth, a power of two

package uart_pkg;

    // ====================
    // Frame
    // ====================

    // One character on the line
    typedef logic [7:0] uart_byte_t;

    // Data bits per frame, LSB first
    localparam int unsigned DATA_BITS = 8;

    // Width of the data bit index
    localparam int unsigned BIT_IDX_W = $clog2(DATA_BITS);

    // System clocks per line bit, kept small for short simulation
    localparam int unsigned CLKS_PER_BIT = 16;

    // Width of the bit period counters
    localparam int unsigned BIT_CNT_W = $clog2(CLKS_PER_BIT);

    // Cycles the receive path spends in the edge filter
    // Two history stages past the sampled stage, plus the state update
    localparam int unsigned RX_FILTER_DELAY = 3;

    // Filtered start edge to start bit centre
    localparam int unsigned HALF_BIT = CLKS_PER_BIT / 2 - RX_FILTER_DELAY;

    // ====================
    // FIFOs and flow control
    // ====================

    localparam int unsigned FIFO_DEPTH = 16;

    // Address width, the occupancy count is one bit wider
    localparam int unsigned FIFO_AW = $clog2(FIFO_DEPTH);

    // Clear-to-send flops, all must read low before a frame starts
    localparam int unsigned CTS_SYNC_STAGES = 3;

    // ====================
    // State machines
    // ====================

    // Data bits share one state, a bit index walks through them
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_HUNT,
        RX_START_MID,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

// File: design/uart_byte_fifo.sv
// Flop-based byte FIFO with the head entry shown ahead of the pop
// Push while full and pop while empty are ignored
// Flags and head update the cycle after a push or pop

module uart_byte_fifo
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_push,
    input  logic       i_pop,
    input  uart_byte_t i_byte,
    output uart_byte_t o_byte,
    output logic       o_empty,
    output logic       o_full
);

    // Byte storage
    uart_byte_t mem [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic [FIFO_AW:0]   count_next;
    logic               push_ok;
    logic               pop_ok;

    // Qualified requests
    assign push_ok = i_push && !o_full;
    assign pop_ok  = i_pop && !o_empty;

    // Occupancy after this cycle
    always_comb
    begin
        count_next = count;
        if (push_ok && !pop_ok)
        begin
            count_next = count + 1'b1;
        end
        else if (pop_ok && !push_ok)
        begin
            count_next = count - 1'b1;
        end
    end

    // Write side
    always_ff @(posedge i_clk)
    begin
        if (push_ok)
        begin
            mem[wr_ptr] <= i_byte;
        end
    end

    // Pointers, count and registered flags
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            o_empty <= 1'b1;
            o_full  <= 1'b0;
        end
        else
        begin
            // Pointers wrap at the power-of-two depth
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count_next;
            o_empty <= (count_next == '0);
            o_full  <= (count_next == (FIFO_AW+1)'(FIFO_DEPTH));
        end
    end

    // Show-ahead head
    assign o_byte = mem[rd_ptr];

endmodule

// File: design/uart_tx_serializer.sv
// Frames start only on a bit tick, so start latency varies by up to one bit
// Pops the FIFO at the start of the stop bit, head must stay stable until then
// A rising clear-to-send lets the current frame finish

module uart_tx_serializer
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_cts_n,
    input  logic       i_empty,
    input  uart_byte_t i_byte,
    output logic       o_pop,
    output logic       o_txd
);

    logic [BIT_CNT_W-1:0]       tick_cnt;
    logic                       tick;
    logic [CTS_SYNC_STAGES-1:0] cts_sync;
    logic                       send_ok;
    logic [BIT_IDX_W-1:0]       bit_idx;
    tx_state_t                  state;

    // ====================
    // Bit period timer
    // ====================

    // Free running, one tick per line bit
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            tick_cnt <= '0;
        end
        else if (tick)
        begin
            tick_cnt <= '0;
        end
        else
        begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick = (tick_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    // ====================
    // Clear-to-send sync
    // ====================

    // Resets to inactive so nothing goes out before the peer is seen
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            cts_sync <= '1;
        end
        else
        begin
            cts_sync <= {cts_sync[CTS_SYNC_STAGES-2:0], i_cts_n};
        end
    end

    // Every stage low and a byte waiting
    assign send_ok = (cts_sync == '0) && !i_empty;

    // ====================
    // Transmit FSM
    // ====================

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state   <= TX_IDLE;
            bit_idx <= '0;
            o_txd   <= 1'b1;
            o_pop   <= 1'b0;
        end
        else
        begin
            // Pop is a single cycle strobe
            o_pop <= 1'b0;
            if (tick)
            begin
                case (state)
                    TX_IDLE:
                    begin
                        if (send_ok)
                        begin
                            o_txd <= 1'b0;
                            state <= TX_START;
                        end
                    end
                    TX_START:
                    begin
                        // Start bit done, first data bit
                        o_txd   <= i_byte[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                    TX_DATA:
                    begin
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
                        begin
                            // Byte fully shifted, release the FIFO entry
                            o_txd <= 1'b1;
                            o_pop <= 1'b1;
                            state <= TX_STOP;
                        end
                        else
                        begin
                            o_txd   <= i_byte[bit_idx + 1'b1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                    TX_STOP:
                    begin
                        // Back to back frames with no idle gap
                        if (send_ok)
                        begin
                            o_txd <= 1'b0;
                            state <= TX_START;
                        end
                        else
                        begin
                            state <= TX_IDLE;
                        end
                    end
                    default:
                    begin
                        o_txd <= 1'b1;
                        state <= TX_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// File: design/uart_rx_deserializer.sv
// Samples the line at each bit centre, no oversampled voting
// A start bit that reads high at its centre is dropped as a glitch
// Hunts only while the FIFO has room, a frame with a low stop bit is not pushed

module uart_rx_deserializer
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_rxd,
    input  logic       i_full,
    output logic       o_push,
    output logic       o_rts_n,
    output uart_byte_t o_byte
);

    logic [1:0]           rxd_sync;
    logic                 rxd_s;
    logic [4:0]           rxd_hist;
    logic                 start_edge;
    logic [BIT_CNT_W-1:0] cnt;
    logic [BIT_IDX_W-1:0] bit_idx;
    rx_state_t            state;

    // ====================
    // Input sync and filter
    // ====================

    // Two flop synchronizer then a five deep history, all idle high
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            rxd_sync <= 2'b11;
            rxd_hist <= 5'h1f;
        end
        else
        begin
            rxd_sync <= {rxd_sync[0], i_rxd};
            rxd_hist <= {rxd_hist[3:0], rxd_s};
        end
    end

    assign rxd_s = rxd_sync[1];

    // Two old samples high, two new samples low
    // Middle stage is ignored to ride over a slow edge
    assign start_edge = (rxd_hist[4:3] == 2'b11) && (rxd_hist[1:0] == 2'b00);

    // Peer stops sending while there is no room
    assign o_rts_n = i_full;

    // ====================
    // Receive FSM
    // ====================

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_push  <= 1'b0;
        end
        else
        begin
            o_push <= 1'b0;
            cnt    <= cnt + 1'b1;
            case (state)
                RX_IDLE:
                begin
                    if (!i_full)
                    begin
                        state <= RX_HUNT;
                    end
                end
                RX_HUNT:
                begin
                    if (i_full)
                    begin
                        state <= RX_IDLE;
                    end
                    else if (start_edge)
                    begin
                        cnt   <= '0;
                        state <= RX_START_MID;
                    end
                end
                RX_START_MID:
                begin
                    // Centre of the start bit
                    if (cnt == BIT_CNT_W'(HALF_BIT - 1))
                    begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA:
                begin
                    if (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1))
                    begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
                        begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP:
                begin
                    // Stop bit centre, byte goes to the FIFO if framed
                    if (cnt == BIT_CNT_W'(CLKS_PER_BIT - 1))
                    begin
                        cnt    <= '0;
                        o_push <= rxd_s;
                        state  <= RX_IDLE;
                    end
                end
                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Shift register, LSB arrives first and walks down from the top
    always_ff @(posedge i_clk)
    begin
        if (state == RX_DATA && cnt == BIT_CNT_W'(CLKS_PER_BIT - 1))
        begin
            o_byte <= {rxd_s, o_byte[DATA_BITS-1:1]};
        end
    end

endmodule

// File: design/uart_core.sv
// UART core on the system clock, fixed bit length from the package
// Strobes have no back-pressure, a push into a full transmit FIFO is lost

module uart_core
    import uart_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_tx_strobe,
    input  logic       i_rx_pop,
    input  logic       i_cts_n,
    input  logic       i_rxd,
    input  uart_byte_t i_tx_byte,
    output logic       o_tx_full,
    output logic       o_rx_empty,
    output logic       o_txd,
    output logic       o_rts_n,
    output uart_byte_t o_rx_byte
);

    // Transmit path
    uart_byte_t tx_head;
    logic       tx_empty;
    logic       tx_pop;

    // Receive path
    uart_byte_t rx_word;
    logic       rx_push;
    logic       rx_full;

    // ====================
    // Transmit
    // ====================

    uart_byte_fifo tx_fifo_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_push  (i_tx_strobe),
        .i_pop   (tx_pop),
        .i_byte  (i_tx_byte),
        .o_byte  (tx_head),
        .o_empty (tx_empty),
        .o_full  (o_tx_full)
    );

    uart_tx_serializer tx_ser_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_cts_n (i_cts_n),
        .i_empty (tx_empty),
        .i_byte  (tx_head),
        .o_pop   (tx_pop),
        .o_txd   (o_txd)
    );

    // ====================
    // Receive
    // ====================

    uart_rx_deserializer rx_des_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_rxd   (i_rxd),
        .i_full  (rx_full),
        .o_push  (rx_push),
        .o_rts_n (o_rts_n),
        .o_byte  (rx_word)
    );

    uart_byte_fifo rx_fifo_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_push  (rx_push),
        .i_pop   (i_rx_pop),
        .i_byte  (rx_word),
        .o_byte  (o_rx_byte),
        .o_empty (o_rx_empty),
        .o_full  (rx_full)
    );

endmodule

// File: dv/uart_properties.sv
// Port-level checks bound into every uart_core instance
// Flag checks are off while i_reset is high

module uart_properties (
    input logic i_clk,
    input logic i_reset,
    input logic o_txd,
    input logic o_tx_full,
    input logic o_rx_empty,
    input logic o_rts_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // Receive FIFO cannot be full and empty at once
    rts_not_while_empty: assert property (
        @(posedge i_clk) disable iff (i_reset) !(o_rts_n && o_rx_empty)
    ) else $error("o_rts_n and o_rx_empty both high");

    // Line idles high straight out of reset
    txd_high_after_reset: assert property (
        @(posedge i_clk) i_reset |=> o_txd
    ) else $error("o_txd low in the cycle after reset");

    flags_known: assert property (
        @(posedge i_clk) disable iff (i_reset) !$isunknown({o_tx_full, o_rx_empty})
    ) else $error("o_tx_full or o_rx_empty unknown outside reset");

endmodule

bind uart_core uart_properties props_i (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .o_txd      (o_txd),
    .o_tx_full  (o_tx_full),
    .o_rx_empty (o_rx_empty),
    .o_rts_n    (o_rts_n)
);

// File: dv/uart_tb.sv
// Reads dv/uart_trace.txt from the project root, one command per line
// o_txd loops back to i_rxd, so every sent byte also lands in the receive FIFO
// Stops at the first mismatch or timeout

module uart_tb
    import uart_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic       i_clk;
    logic       i_reset;
    logic       i_tx_strobe;
    logic       i_rx_pop;
    logic       i_cts_n;
    uart_byte_t i_tx_byte;
    logic       o_tx_full;
    logic       o_rx_empty;
    logic       o_txd;
    logic       o_rts_n;
    uart_byte_t o_rx_byte;

    // Strobe gap generator state
    logic [31:0] lfsr_state;
    // Trace line under execution, for error lines
    int          cur_line;

    // Transmit line wired straight back into the receiver
    uart_core dut_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_tx_strobe (i_tx_strobe),
        .i_rx_pop    (i_rx_pop),
        .i_cts_n     (i_cts_n),
        .i_rxd       (o_txd),
        .i_tx_byte   (i_tx_byte),
        .o_tx_full   (o_tx_full),
        .o_rx_empty  (o_rx_empty),
        .o_txd       (o_txd),
        .o_rts_n     (o_rts_n),
        .o_rx_byte   (o_rx_byte)
    );

    // 8 ns period
    always #4 i_clk = ~i_clk;

    // ====================
    // Random gaps
    // ====================

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One step per bit taken
    task automatic take_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    // ====================
    // Checks
    // ====================

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input uart_byte_t expected,
                              input uart_byte_t actual);
        if (actual !== expected)
        begin
            $display("FAIL t=%0t %s expected %h actual %h (trace line %0d)",
                     $time, name, expected, actual, cur_line);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("FAIL t=%0t %s expected %b actual %b (trace line %0d)",
                     $time, name, expected, actual, cur_line);
            stop_run();
        end
    endtask

    // ====================
    // Trace commands
    // ====================

    // Consecutive values from first, a random idle gap before each strobe
    task automatic push_bytes(input uart_byte_t first, input int count);
        logic [1:0] gap;
        for (int i = 0; i < count; i++)
        begin
            take_bit(gap[0]);
            take_bit(gap[1]);
            repeat (gap) @(posedge i_clk);
            @(posedge i_clk);
            i_tx_strobe <= 1'b1;
            i_tx_byte   <= first + uart_byte_t'(i);
            @(posedge i_clk);
            i_tx_strobe <= 1'b0;
        end
    endtask

    // Wait for data, compare the head byte, then pop it
    task automatic pop_expect(input uart_byte_t first, input int count);
        int waited;
        for (int i = 0; i < count; i++)
        begin
            waited = 0;
            @(negedge i_clk);
            while (o_rx_empty !== 1'b0)
            begin
                if (waited >= 24 * CLKS_PER_BIT)
                begin
                    $display("Timeout: no received byte within 24 bit periods (trace line %0d)",
                             cur_line);
                    stop_run();
                end
                @(negedge i_clk);
                waited++;
            end
            check_byte("o_rx_byte", first + uart_byte_t'(i), o_rx_byte);
            @(posedge i_clk);
            i_rx_pop <= 1'b1;
            @(posedge i_clk);
            i_rx_pop <= 1'b0;
        end
    endtask

    task automatic wait_rts(input logic level, input int limit_bits);
        int waited;
        waited = 0;
        @(negedge i_clk);
        while (o_rts_n !== level)
        begin
            if (waited >= limit_bits * CLKS_PER_BIT)
            begin
                $display("Timeout: o_rts_n did not reach %b within %0d bit periods (line %0d)",
                         level, limit_bits, cur_line);
                stop_run();
            end
            @(negedge i_clk);
            waited++;
        end
    endtask

    // Finds a falling edge on o_txd, then reads each bit at its centre
    task automatic sample_frame(input uart_byte_t expected);
        logic prev;
        int   waited;
        waited = 0;
        @(negedge i_clk);
        prev = o_txd;
        @(negedge i_clk);
        while (!(prev === 1'b1 && o_txd === 1'b0))
        begin
            if (waited >= 4 * CLKS_PER_BIT)
            begin
                $display("Timeout: no start bit on o_txd within 4 bit periods (line %0d)",
                         cur_line);
                stop_run();
            end
            prev = o_txd;
            @(negedge i_clk);
            waited++;
        end
        // First cycle of the start bit, walk on to its centre
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge i_clk);
        check_flag("o_txd start bit", 1'b0, o_txd);
        // LSB first
        for (int i = 0; i < DATA_BITS; i++)
        begin
            repeat (CLKS_PER_BIT) @(negedge i_clk);
            check_flag($sformatf("o_txd data bit %0d", i), expected[i], o_txd);
        end
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        check_flag("o_txd stop bit", 1'b1, o_txd);
    endtask

    // Line must not move for the whole span
    task automatic watch_idle_line(input int bits);
        repeat (bits * CLKS_PER_BIT)
        begin
            @(negedge i_clk);
            check_flag("o_txd", 1'b1, o_txd);
        end
    endtask

    task automatic run_trace();
        int         fd;
        string      line;
        logic [7:0] op;
        int         a;
        int         b;
        int         n;
        fd = $fopen("dv/uart_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the trace file dv/uart_trace.txt");
            stop_run();
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            cur_line++;
            // Comments and blank lines
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n" ||
                line.getc(0) == "\r" || line.getc(0) == " ")
            begin
                continue;
            end
            n = $sscanf(line, "%c %h %d", op, a, b);
            if (n != 3)
            begin
                $display("Malformed trace line %0d", cur_line);
                stop_run();
            end
            case (op)
                "C":
                begin
                    @(posedge i_clk);
                    i_cts_n <= a[0];
                end
                "P": push_bytes(uart_byte_t'(a), b);
                "W": repeat (b * CLKS_PER_BIT) @(posedge i_clk);
                "R": pop_expect(uart_byte_t'(a), b);
                "F":
                begin
                    @(negedge i_clk);
                    check_flag("o_tx_full", a[0], o_tx_full);
                    check_flag("o_rx_empty", b[0], o_rx_empty);
                end
                "T":
                begin
                    @(negedge i_clk);
                    check_flag("o_rts_n", a[0], o_rts_n);
                end
                "U": wait_rts(a[0], b);
                "S": sample_frame(uart_byte_t'(a));
                "I": watch_idle_line(b);
                default:
                begin
                    $display("Unknown command on trace line %0d", cur_line);
                    stop_run();
                end
            endcase
        end
        $fclose(fd);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_tx_strobe = 1'b0;
        i_rx_pop    = 1'b0;
        i_cts_n     = 1'b1;
        i_tx_byte   = '0;
        lfsr_state  = 32'd69948;
        cur_line    = 0;
        // Five clocks of reset
        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        run_trace();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: dv/uart_trace.txt
# columns: op a b, with op one letter, a in hex, b in decimal, unused fields 0
# C cts_n | P first n | W - bits | R first n | F full empty | T rts_n | U rts_n limit | S byte | I - bits

# Reset state
F 0 1
T 0 0
I 0 2

# Frame shape on the first transmitted byte
C 0 0
W 0 2
P a5 1
S a5 0
R a5 1
F 0 1

# Loopback order
P 40 8
R 40 8
P c3 1
P 5a 1
P 00 1
P ff 1
R c3 1
R 5a 1
R 00 1
R ff 1
F 0 1
T 0 0

# Clear-to-send hold, extra push is dropped
C 1 0
W 0 2
P 80 16
F 1 1
P ee 1
I 0 20
C 0 0
R 80 16
W 0 24
F 0 1

# Receive FIFO full, 17th frame is not stored
P 20 16
W 0 12
P 30 1
U 1 200
W 0 14
T 1 0
F 0 0
R 20 1
T 0 0
R 21 15
W 0 12
F 0 1
T 0 0

// File: list.f
design/uart_pkg.sv
design/uart_byte_fifo.sv
design/uart_tx_serializer.sv
design/uart_rx_deserializer.sv
design/uart_core.sv
dv/uart_properties.sv
dv/uart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module uart_tb -f list.f -o uart_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/uart_sim > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
cat sim.log

grep -q -F "=== FAIL ===" sim.log && { echo "Result: failed"; exit 1; }
grep -q -F "=== PASS ===" sim.log || { echo "Result: failed, no pass line"; exit 1; }
echo "Result: passed"
